//--- logic/wbFabric_settings.svh
`ifndef WBFABRIC_SETTINGS_SVH
`define WBFABRIC_SETTINGS_SVH

// --------------------------------------------------
// Host bus geometry
// --------------------------------------------------
`define WB_ADR_WIDTH    12      // Word address
`define WB_DAT_WIDTH    32      // Data bus
`define WB_SEL_WIDTH    4       // One strobe per byte lane

// Region field in the word address
// 00 regs, 01 RAM1, 10 RAM2, 11 RAM3
`define WB_REGION_MSB   11
`define WB_REGION_LSB   10

// --------------------------------------------------
// Memory depths, in words
// --------------------------------------------------
`define RAM1_DEPTH      512     // 512x16
`define RAM2_DEPTH      1024    // 1024x8
`define RAM3_DEPTH      512     // 512x32

// Value returned by the ID register
`define FAB_ID_VALUE    32'hFABDEFAC

`endif

//--- logic/wbFabricPkg.sv
`default_nettype none

`include "wbFabric_settings.svh"

package wbFabricPkg;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    typedef enum logic [1:0]
    {
        REGION_REGS = 2'b00,    // Control registers
        REGION_RAM1 = 2'b01,    // 512x16
        REGION_RAM2 = 2'b10,    // 1024x8
        REGION_RAM3 = 2'b11     // 512x32
    } regionE;

    // Word offsets in the register region, offset 3 unmapped
    typedef enum logic [1:0]
    {
        REG_ID       = 2'd0,
        REG_SCRATCH  = 2'd1,
        REG_XFER_CNT = 2'd2
    } regOffsetE;

    // --------------------------------------------------
    // Bus bundles
    // --------------------------------------------------
    typedef struct packed
    {
        logic [`WB_ADR_WIDTH-1:0] adr;  // Word address
        logic [`WB_DAT_WIDTH-1:0] dat;  // Write data
        logic [`WB_SEL_WIDTH-1:0] sel;  // Byte strobes
        logic                     we;   // Write enable
        logic                     stb;  // Transfer strobe
    } wbReqS;

    // One-hot region selects, regs in bit 0
    typedef struct packed
    {
        logic ram3;
        logic ram2;
        logic ram1;
        logic regs;
    } cycSelS;

    typedef struct packed
    {
        logic                     ack;  // Single-cycle acknowledge
        logic [`WB_DAT_WIDTH-1:0] dat;  // Valid while ack high
    } wbRspS;

endpackage

`default_nettype wire

//--- logic/syncRam.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioural byte-lane RAM, single port, registered read
module syncRam #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 512,
    localparam int LANES      = DATA_WIDTH / 8,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
)
(
    input  wire                   WBs_CLK_i,
    input  wire [LANES-1:0]       wrEn_i,     // One enable per byte lane
    input  wire [ADDR_WIDTH-1:0]  addr_i,
    input  wire [DATA_WIDTH-1:0]  wrDat_i,
    output logic [DATA_WIDTH-1:0] rdDat_o
);

    // Storage, no reset on contents
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        for (int lane = 0; lane < LANES; lane++)
        begin
            if (wrEn_i[lane])
            begin
                mem[addr_i][lane*8 +: 8] <= wrDat_i[lane*8 +: 8];
            end
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    // Sampled every edge; same-edge write still
    // returns the old word
    always_ff @(posedge WBs_CLK_i)
    begin
        rdDat_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- logic/wbFabricRams.sv
`timescale 1ns/1ps
`default_nettype none

`include "wbFabric_settings.svh"

module wbFabricRams (
    input  wire                            WBs_CLK_i,
    input  wire wbFabricPkg::wbReqS        wbReq_i,
    input  wire wbFabricPkg::cycSelS       cycSel_i,
    input  wire                            accept_i,
    output logic [`WB_DAT_WIDTH-1:0]       ram1Dat_o,
    output logic [`WB_DAT_WIDTH-1:0]       ram2Dat_o,
    output logic [`WB_DAT_WIDTH-1:0]       ram3Dat_o
);

    // Stored widths and address widths per RAM
    localparam int RAM1_DW = 16;
    localparam int RAM2_DW = 8;
    localparam int RAM3_DW = 32;
    localparam int RAM1_AW = $clog2(`RAM1_DEPTH);   // Bits 8:0, bit 9 aliases
    localparam int RAM2_AW = $clog2(`RAM2_DEPTH);   // Bits 9:0
    localparam int RAM3_AW = $clog2(`RAM3_DEPTH);   // Bits 8:0

    logic                   ram1Wr;
    logic                   ram2Wr;
    logic                   ram3Wr;
    logic [RAM1_DW/8-1:0]   ram1WrEn;
    logic [RAM2_DW/8-1:0]   ram2WrEn;
    logic [RAM3_DW/8-1:0]   ram3WrEn;
    logic [RAM1_DW-1:0]     ram1Rd;
    logic [RAM2_DW-1:0]     ram2Rd;
    logic [RAM3_DW-1:0]     ram3Rd;

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------
    // Accept is high for one edge per transfer, so each write lands once
    assign ram1Wr = cycSel_i.ram1 & accept_i & wbReq_i.we;
    assign ram2Wr = cycSel_i.ram2 & accept_i & wbReq_i.we;
    assign ram3Wr = cycSel_i.ram3 & accept_i & wbReq_i.we;

    // Lane enables from the byte strobes of the stored lanes only
    assign ram1WrEn = {(RAM1_DW/8){ram1Wr}} & wbReq_i.sel[RAM1_DW/8-1:0];
    assign ram2WrEn = {(RAM2_DW/8){ram2Wr}} & wbReq_i.sel[RAM2_DW/8-1:0];
    assign ram3WrEn = {(RAM3_DW/8){ram3Wr}} & wbReq_i.sel[RAM3_DW/8-1:0];

    // --------------------------------------------------
    // Memories
    // --------------------------------------------------
    syncRam #(.DATA_WIDTH(RAM1_DW), .DEPTH(`RAM1_DEPTH)) ram1 (
        .WBs_CLK_i (WBs_CLK_i),
        .wrEn_i    (ram1WrEn),
        .addr_i    (wbReq_i.adr[RAM1_AW-1:0]),
        .wrDat_i   (wbReq_i.dat[RAM1_DW-1:0]),      // Lanes 0 and 1
        .rdDat_o   (ram1Rd)
    );

    syncRam #(.DATA_WIDTH(RAM2_DW), .DEPTH(`RAM2_DEPTH)) ram2 (
        .WBs_CLK_i (WBs_CLK_i),
        .wrEn_i    (ram2WrEn),
        .addr_i    (wbReq_i.adr[RAM2_AW-1:0]),
        .wrDat_i   (wbReq_i.dat[RAM2_DW-1:0]),      // Lane 0
        .rdDat_o   (ram2Rd)
    );

    syncRam #(.DATA_WIDTH(RAM3_DW), .DEPTH(`RAM3_DEPTH)) ram3 (
        .WBs_CLK_i (WBs_CLK_i),
        .wrEn_i    (ram3WrEn),
        .addr_i    (wbReq_i.adr[RAM3_AW-1:0]),
        .wrDat_i   (wbReq_i.dat[RAM3_DW-1:0]),      // Full word
        .rdDat_o   (ram3Rd)
    );

    // Narrow words zero extended onto the bus
    assign ram1Dat_o = {{(`WB_DAT_WIDTH-RAM1_DW){1'b0}}, ram1Rd};
    assign ram2Dat_o = {{(`WB_DAT_WIDTH-RAM2_DW){1'b0}}, ram2Rd};
    assign ram3Dat_o = ram3Rd;

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Relies on the decoder keeping the selects exclusive
    ramWrExclusive: assert property (@(posedge WBs_CLK_i)
        $onehot0({|ram1WrEn, |ram2WrEn, |ram3WrEn}))
        else $error("More than one RAM written in one cycle");

endmodule

`default_nettype wire

//--- logic/wbFabricRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "wbFabric_settings.svh"

module wbFabricRegs (
    input  wire                            WBs_CLK_i,
    input  wire                            WBs_RST_i,
    input  wire wbFabricPkg::wbReqS        wbReq_i,
    input  wire wbFabricPkg::cycSelS       cycSel_i,
    input  wire                            accept_i,
    output logic [`WB_DAT_WIDTH-1:0]       regsDat_o
);

    wbFabricPkg::regOffsetE     offset;         // Low two address bits
    logic                       regWr;
    logic                       scratchWr;
    logic                       xferCntWr;
    logic [`WB_DAT_WIDTH-1:0]   scratch;
    logic [`WB_DAT_WIDTH-1:0]   xferCnt;
    logic [`WB_DAT_WIDTH-1:0]   xferCntInc;
    logic [`WB_DAT_WIDTH-1:0]   rdNxt;
    logic [`WB_DAT_WIDTH-1:0]   rdQ;

    // Upper address bits in the region alias
    assign offset = wbFabricPkg::regOffsetE'(wbReq_i.adr[1:0]);

    // --------------------------------------------------
    // Write decode
    // --------------------------------------------------
    assign regWr     = cycSel_i.regs & accept_i & wbReq_i.we;
    assign scratchWr = regWr & (offset == wbFabricPkg::REG_SCRATCH);
    assign xferCntWr = regWr & (offset == wbFabricPkg::REG_XFER_CNT);   // Any strobes

    // Scratch, byte-wise merge
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            scratch <= '0;
        end
        else if (scratchWr)
        begin
            for (int lane = 0; lane < `WB_SEL_WIDTH; lane++)
            begin
                if (wbReq_i.sel[lane])
                begin
                    scratch[lane*8 +: 8] <= wbReq_i.dat[lane*8 +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Transfer counter
    // --------------------------------------------------
    // Every accepted transfer to any region counts
    assign xferCntInc = xferCnt + `WB_DAT_WIDTH'(1);

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            xferCnt <= '0;
        end
        else if (xferCntWr)
        begin
            xferCnt <= '0;                  // Clear wins over count
        end
        else if (accept_i)
        begin
            xferCnt <= xferCntInc;
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    always_comb
    begin
        case (offset)
            wbFabricPkg::REG_ID:       rdNxt = `FAB_ID_VALUE;  // Read-only
            wbFabricPkg::REG_SCRATCH:  rdNxt = scratch;
            wbFabricPkg::REG_XFER_CNT: rdNxt = xferCntInc;     // Includes this read
            default:                   rdNxt = '0;             // Offset 3
        endcase
    end

    // Captured on the accept edge, valid during ack
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            rdQ <= '0;
        end
        else if (accept_i & cycSel_i.regs)
        begin
            rdQ <= rdNxt;
        end
    end

    assign regsDat_o = rdQ;

endmodule

`default_nettype wire

//--- logic/wbBusDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "wbFabric_settings.svh"

module wbBusDecode (
    input  wire                            WBs_CLK_i,
    input  wire                            WBs_RST_i,
    input  wire wbFabricPkg::wbReqS        wbReq_i,
    input  wire [`WB_DAT_WIDTH-1:0]        regsDat_i,
    input  wire [`WB_DAT_WIDTH-1:0]        ram1Dat_i,
    input  wire [`WB_DAT_WIDTH-1:0]        ram2Dat_i,
    input  wire [`WB_DAT_WIDTH-1:0]        ram3Dat_i,
    output wbFabricPkg::cycSelS            cycSel_o,
    output logic                           accept_o,
    output wbFabricPkg::wbRspS             wbRsp_o
);

    wbFabricPkg::regionE        region;
    logic                       ackQ;
    logic [`WB_DAT_WIDTH-1:0]   rdMux;

    // --------------------------------------------------
    // Region decode
    // --------------------------------------------------
    assign region = wbFabricPkg::regionE'(wbReq_i.adr[`WB_REGION_MSB:`WB_REGION_LSB]);

    // One-hot select follows the address
    always_comb
    begin
        cycSel_o = '0;
        case (region)
            wbFabricPkg::REGION_REGS: cycSel_o.regs = 1'b1;
            wbFabricPkg::REGION_RAM1: cycSel_o.ram1 = 1'b1;
            wbFabricPkg::REGION_RAM2: cycSel_o.ram2 = 1'b1;
            wbFabricPkg::REGION_RAM3: cycSel_o.ram3 = 1'b1;
            default:                  cycSel_o      = '0;
        endcase
    end

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    // Own ack blocks a second accept on a held strobe
    assign accept_o = wbReq_i.stb & ~ackQ;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ackQ <= 1'b0;
        end
        else
        begin
            ackQ <= accept_o;               // One cycle after strobe
        end
    end

    // --------------------------------------------------
    // Read return
    // --------------------------------------------------
    // Address is still held during ack, so it steers the mux
    always_comb
    begin
        case (region)
            wbFabricPkg::REGION_REGS: rdMux = regsDat_i;
            wbFabricPkg::REGION_RAM1: rdMux = ram1Dat_i;
            wbFabricPkg::REGION_RAM2: rdMux = ram2Dat_i;
            wbFabricPkg::REGION_RAM3: rdMux = ram3Dat_i;
            default:                  rdMux = '0;
        endcase
    end

    assign wbRsp_o.ack = ackQ;
    assign wbRsp_o.dat = rdMux;

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    ackSinglePulse: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        ackQ |=> !ackQ)
        else $error("Ack high in two consecutive cycles");

    // Downstream write decode depends on exclusive selects
    selOneHot: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        wbReq_i.stb |-> $onehot(cycSel_o))
        else $error("Region select not one-hot during strobe");

endmodule

`default_nettype wire

//--- logic/wbFabricTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "wbFabric_settings.svh"

module wbFabricTop (
    input  wire                            WBs_CLK_i,
    input  wire                            WBs_RST_i,
    input  wire wbFabricPkg::wbReqS        wbReq_i,   // Host transfer
    output wbFabricPkg::wbRspS             wbRsp_o    // Ack plus read data
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    wbFabricPkg::cycSelS        cycSel;     // One-hot region select
    logic                       accept;     // Strobe seen, ack not yet given
    logic [`WB_DAT_WIDTH-1:0]   regsDat;
    logic [`WB_DAT_WIDTH-1:0]   ram1Dat;
    logic [`WB_DAT_WIDTH-1:0]   ram2Dat;
    logic [`WB_DAT_WIDTH-1:0]   ram3Dat;

    // Decode, ack and read return
    wbBusDecode busDecode (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .wbReq_i   (wbReq_i),
        .regsDat_i (regsDat),
        .ram1Dat_i (ram1Dat),
        .ram2Dat_i (ram2Dat),
        .ram3Dat_i (ram3Dat),
        .cycSel_o  (cycSel),
        .accept_o  (accept),
        .wbRsp_o   (wbRsp_o)
    );

    // Three memories, contents not reset
    wbFabricRams fabricRams (
        .WBs_CLK_i (WBs_CLK_i),
        .wbReq_i   (wbReq_i),
        .cycSel_i  (cycSel),
        .accept_i  (accept),
        .ram1Dat_o (ram1Dat),
        .ram2Dat_o (ram2Dat),
        .ram3Dat_o (ram3Dat)
    );

    // ID, scratch and transfer counter
    wbFabricRegs fabricRegs (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .wbReq_i   (wbReq_i),
        .cycSel_i  (cycSel),
        .accept_i  (accept),
        .regsDat_o (regsDat)
    );

endmodule

`default_nettype wire

//--- tests/wbFabricTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "wbFabric_settings.svh"

module wbFabricTb;

    localparam int ACK_TIMEOUT = 20;        // Cycles per bus wait

    logic                   WBs_CLK_i;
    logic                   WBs_RST_i;
    wbFabricPkg::wbReqS     wbReq;
    wbFabricPkg::wbRspS     wbRsp;

    logic [31:0]            lfsrState;
    int                     errCount;
    int                     checkTotal;
    int                     testCount;
    int                     testErrStart;

    // Reference contents of the three RAMs
    logic [15:0]            ram1Ref [`RAM1_DEPTH];
    logic [7:0]             ram2Ref [`RAM2_DEPTH];
    logic [31:0]            ram3Ref [`RAM3_DEPTH];

    wbFabricTop DUT (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .wbReq_i   (wbReq),
        .wbRsp_o   (wbRsp)
    );

    // 4 ns clock
    initial
    begin
        WBs_CLK_i = 1'b0;
        forever #2 WBs_CLK_i = ~WBs_CLK_i;
    end

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);    // One step per bit
            val = {val[30:0], lfsrState[0]};
        end
        return val;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic checkData(input logic [`WB_DAT_WIDTH-1:0] got,
                             input logic [`WB_DAT_WIDTH-1:0] exp, input string msg);
        checkTotal++;
        if (got !== exp)
        begin
            errCount++;
            $display("ERR @%0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkRsp(input wbFabricPkg::wbRspS got, input wbFabricPkg::wbRspS exp,
                            input string msg);
        checkTotal++;
        if (got !== exp)
        begin
            errCount++;
            $display("ERR @%0t: %s got ack %b dat %h expected ack %b dat %h",
                     $time, msg, got.ack, got.dat, exp.ack, exp.dat);
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string msg);
        checkTotal++;
        if (got != exp)
        begin
            errCount++;
            $display("ERR @%0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    function automatic wbFabricPkg::wbRspS ackWith(input logic [`WB_DAT_WIDTH-1:0] dat);
        wbFabricPkg::wbRspS rsp;
        rsp.ack = 1'b1;
        rsp.dat = dat;
        return rsp;
    endfunction

    // --------------------------------------------------
    // Bus transfers
    // --------------------------------------------------
    task automatic busXfer(input logic [11:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic we,
                           output wbFabricPkg::wbRspS rsp);
        int waitCycles;
        bit gotAck;
        waitCycles = 0;
        gotAck     = 1'b0;
        rsp        = '0;
        @(negedge WBs_CLK_i);
        wbReq.adr = adr;
        wbReq.dat = dat;
        wbReq.sel = sel;
        wbReq.we  = we;
        wbReq.stb = 1'b1;
        while (!gotAck && waitCycles < ACK_TIMEOUT)
        begin
            @(negedge WBs_CLK_i);
            waitCycles++;
            if (wbRsp.ack)
            begin
                gotAck = 1'b1;
                rsp    = wbRsp;             // Data valid only now
            end
        end
        if (!gotAck)
        begin
            errCount++;
            $display("No ack from the fabric within %0d cycles, address %h",
                     ACK_TIMEOUT, adr);
        end
        else
        begin
            checkCount(waitCycles, 1, "strobe to ack latency");
            // Strobe still held here, ack must not repeat
            @(negedge WBs_CLK_i);
            checkCount(wbRsp.ack ? 2 : 1, 1, "acks per transfer");
        end
        wbReq = '0;
    endtask

    task automatic wbWrite(input logic [11:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
        wbFabricPkg::wbRspS rsp;
        busXfer(adr, dat, sel, 1'b1, rsp);
    endtask

    task automatic wbRead(input logic [11:0] adr, output wbFabricPkg::wbRspS rsp);
        busXfer(adr, '0, 4'hF, 1'b0, rsp);
    endtask

    // RAM model, full-word writes only
    function automatic void modelWrite(input logic [11:0] adr, input logic [31:0] dat);
        case (adr[11:10])
            2'b01:   ram1Ref[adr[8:0]] = dat[15:0];     // Bit 9 aliases
            2'b10:   ram2Ref[adr[9:0]] = dat[7:0];
            default: ram3Ref[adr[8:0]] = dat;
        endcase
    endfunction

    function automatic logic [31:0] modelRead(input logic [11:0] adr);
        case (adr[11:10])
            2'b01:   return {16'h0, ram1Ref[adr[8:0]]};
            2'b10:   return {24'h0, ram2Ref[adr[9:0]]};
            default: return ram3Ref[adr[8:0]];
        endcase
    endfunction

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic testResetValues();
        wbFabricPkg::wbRspS rsp;
        wbRead(12'h000, rsp);
        checkRsp(rsp, ackWith(`FAB_ID_VALUE), "ID after reset");
        wbRead(12'h001, rsp);
        checkRsp(rsp, ackWith(32'h0), "scratch after reset");
        wbRead(12'h003, rsp);
        checkRsp(rsp, ackWith(32'h0), "unmapped offset 3");
    endtask

    task automatic testScratchStrobes();
        wbFabricPkg::wbRspS rsp;
        wbWrite(12'h001, 32'h01020304, 4'hF);
        wbRead(12'h001, rsp);
        checkRsp(rsp, ackWith(32'h01020304), "scratch full write");
        wbWrite(12'h001, 32'hAABBCCDD, 4'b1001);
        wbRead(12'h001, rsp);
        checkRsp(rsp, ackWith(32'hAA0203DD), "scratch lanes 3 and 0");
        wbWrite(12'h001, 32'h11223344, 4'b0110);
        wbRead(12'h3F5, rsp);                       // Aliased scratch offset
        checkRsp(rsp, ackWith(32'hAA2233DD), "scratch lanes 2 and 1");
        wbRead(12'h003, rsp);                       // Scratch now nonzero
        checkRsp(rsp, ackWith(32'h0), "unmapped offset 3 with scratch set");
        wbWrite(12'h000, 32'h12345678, 4'hF);
        wbRead(12'h000, rsp);
        checkRsp(rsp, ackWith(`FAB_ID_VALUE), "ID after write attempt");
    endtask

    task automatic testNarrowRams();
        wbFabricPkg::wbRspS rsp;
        wbWrite(12'h4A5, 32'hDEADBEEF, 4'hF);       // RAM1 word 0A5
        wbRead(12'h4A5, rsp);
        checkRsp(rsp, ackWith(32'h0000BEEF), "RAM1 low lanes only");
        wbRead(12'h6A5, rsp);
        checkRsp(rsp, ackWith(32'h0000BEEF), "RAM1 bit 9 alias read");
        wbWrite(12'h6A5, 32'h12345678, 4'b0010);
        wbRead(12'h4A5, rsp);
        checkRsp(rsp, ackWith(32'h000056EF), "RAM1 lane 1 via alias");
        wbWrite(12'hBFF, 32'hCAFEBA5E, 4'hF);       // RAM2 word 3FF
        wbRead(12'hBFF, rsp);
        checkRsp(rsp, ackWith(32'h0000005E), "RAM2 lane 0 only");
        wbWrite(12'hBFF, 32'h000000FF, 4'b1110);    // No stored lane enabled
        wbWrite(12'h9FF, 32'h00000077, 4'hF);       // Bit 9 decoded in RAM2
        wbRead(12'hBFF, rsp);
        checkRsp(rsp, ackWith(32'h0000005E), "RAM2 unaffected word");
    endtask

    task automatic testRam3Merge();
        wbFabricPkg::wbRspS rsp;
        wbWrite(12'hD55, 32'h11223344, 4'hF);
        wbWrite(12'hD55, 32'hAABBCCDD, 4'b0101);
        wbRead(12'hD55, rsp);
        checkRsp(rsp, ackWith(32'h11BB33DD), "RAM3 lanes 2 and 0");
        wbWrite(12'hD55, 32'h55667788, 4'b1010);
        wbRead(12'hD55, rsp);
        checkRsp(rsp, ackWith(32'h55BB77DD), "RAM3 lanes 3 and 1");
        wbWrite(12'hD55, 32'hFFFFFFFF, 4'b0000);
        wbRead(12'hD55, rsp);
        checkRsp(rsp, ackWith(32'h55BB77DD), "RAM3 with no strobes");
    endtask

    task automatic testRandomRams();
        logic [11:0]        adrList [$];
        logic [11:0]        adr;
        logic [31:0]        dat;
        wbFabricPkg::wbRspS rsp;
        for (int i = 0; i < 16; i++)
        begin
            adr = {2'(1 + randBits(2) % 3), 10'(randBits(10))};    // RAM regions only
            dat = randBits(32);
            wbWrite(adr, dat, 4'hF);
            modelWrite(adr, dat);
            adrList.push_back(adr);
        end
        foreach (adrList[i])
        begin
            wbRead(adrList[i], rsp);
            checkData(rsp.dat, modelRead(adrList[i]), $sformatf("random read %h", adrList[i]));
        end
    endtask

    task automatic testXferCount();
        wbFabricPkg::wbRspS rsp;
        wbWrite(12'h002, 32'hFFFFFFFF, 4'hF);       // Clear
        wbWrite(12'h001, 32'h00000001, 4'hF);
        wbRead(12'h000, rsp);
        wbWrite(12'h001, 32'h00000002, 4'b0001);
        wbRead(12'h000, rsp);
        wbWrite(12'hC10, 32'h00000003, 4'hF);       // Other regions count too
        wbRead(12'h002, rsp);
        checkRsp(rsp, ackWith(32'd6), "count of five plus the read");
        wbRead(12'h006, rsp);                       // Aliased counter offset
        checkRsp(rsp, ackWith(32'd7), "count after one more read");
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount == testErrStart)
        begin
            $display("test %0d %s: ok", testCount, name);
        end
        else
        begin
            $display("test %0d %s: %0d errors", testCount, name, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    // --------------------------------------------------
    // Sequence
    // --------------------------------------------------
    initial
    begin
        WBs_RST_i    = 1'b1;
        wbReq        = '0;
        lfsrState    = 32'h662d2edf;
        errCount     = 0;
        checkTotal   = 0;
        testCount    = 0;
        testErrStart = 0;
        repeat (8) @(posedge WBs_CLK_i);
        @(negedge WBs_CLK_i);
        WBs_RST_i = 1'b0;

        testResetValues();
        finishTest("reset values");
        testScratchStrobes();
        finishTest("scratch strobes");
        testNarrowRams();
        finishTest("narrow RAMs");
        testRam3Merge();
        finishTest("RAM3 merge");
        testRandomRams();
        finishTest("random RAM traffic");
        testXferCount();
        finishTest("transfer counter");

        $display("tests %0d, checks %0d, errors %0d", testCount, checkTotal, errCount);
        if (errCount == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+logic
logic/wbFabricPkg.sv
logic/syncRam.sv
logic/wbFabricRams.sv
logic/wbFabricRegs.sv
logic/wbBusDecode.sv
logic/wbFabricTop.sv
tests/wbFabricTb.sv
